/* build.f */
+incdir+verif
rtl/cin_link_pkg.sv
rtl/cin_cmd_pkg.sv
rtl/cin_nybble_delay.sv
rtl/cin_parallel_sync.sv
rtl/cin_word_fifo.sv
rtl/cin_cmd_decoder.sv
rtl/cin_link_top.sv
verif/cin_link_tb.sv

/* rtl/cin_cmd_decoder.sv */
`timescale 1ns/1ns

module cin_cmd_decoder (
    input  logic                    sysclk_i,
    input  logic                    rst_i,
    input  cin_link_pkg::cin_word_t word_i,
    input  logic                    empty_i,
    output logic                    rd_o,
    output logic                    trig_o,
    output cin_cmd_pkg::cin_trig_t  trig_time_o,
    output logic                    regwr_o,
    output cin_cmd_pkg::cin_regwr_t regwr_data_o,
    output logic [7:0]              bad_cmd_cnt_o
);
    import cin_link_pkg::*;
    import cin_cmd_pkg::*;

    localparam int WORD_W  = $bits(cin_word_t);
    localparam int OP_W    = $bits(cin_opcode_e);
    // Field width below the opcode
    localparam int FIELD_W = WORD_W - OP_W;

    logic                  pending;
    cin_opcode_e           opcode;
    logic [FIELD_W-1:0]    field;
    logic                  is_trig;
    logic                  is_regwr;
    logic                  is_bad;

    // Pop as soon as a word is there and the last pop has landed
    assign rd_o = !empty_i && !pending;

    // Word from the FIFO is valid the cycle after the pop
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            pending <= 1'b0;
        end else begin
            pending <= rd_o;
        end
    end

    // Split the word
    assign opcode = cin_opcode_e'(word_i[WORD_W-1 -: OP_W]);
    assign field  = word_i[FIELD_W-1:0];

    // Opcode classes
    always_comb begin
        is_trig  = 1'b0;
        is_regwr = 1'b0;
        is_bad   = 1'b0;
        case (opcode)
            OP_TRIG:  is_trig = 1'b1;
            OP_REGWR: is_regwr = 1'b1;
            // Idle and training need no action
            OP_IDLE, OP_TRAIN: is_bad = 1'b0;
            default:  is_bad = 1'b1;
        endcase
    end

    // Output pulses
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            trig_o  <= 1'b0;
            regwr_o <= 1'b0;
        end else begin
            trig_o  <= pending && is_trig;
            regwr_o <= pending && is_regwr;
        end
    end

    // Field registers only load with their own command
    // Valid alongside the matching pulse
    always_ff @(posedge sysclk_i) begin
        if (pending && is_trig) begin
            trig_time_o <= cin_trig_t'(field);
        end
        if (pending && is_regwr) begin
            regwr_data_o <= cin_regwr_t'(field);
        end
    end

    // Unknown opcodes counted up to full scale then held
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            bad_cmd_cnt_o <= '0;
        end else if (pending && is_bad && (bad_cmd_cnt_o != '1)) begin
            bad_cmd_cnt_o <= bad_cmd_cnt_o + 1'b1;
        end
    end

endmodule

/* rtl/cin_cmd_pkg.sv */
package cin_cmd_pkg;

    // Opcode in the top nybble of a command word
    // Anything not listed here is a bad command
    typedef enum logic [3:0] {
        // Nothing to do
        OP_IDLE  = 4'h0,
        // Fire a trigger at the given time
        OP_TRIG  = 4'h1,
        // Write a register on the board
        OP_REGWR = 4'h2,
        // Training pattern leaks through as a no-op
        OP_TRAIN = 4'hA
    } cin_opcode_e;

    // Trigger command fields
    // Time occupies all of word bits 27 to 0
    typedef struct packed {
        logic [27:0] trig_time;
    } cin_trig_t;

    // Register write command fields
    // Address in word bits 27 to 20
    // Data in word bits 19 to 0
    typedef struct packed {
        logic [7:0]  addr;
        logic [19:0] data;
    } cin_regwr_t;

endpackage

/* rtl/cin_link_pkg.sv */
package cin_link_pkg;

    // Framing of the 4-bit command link
    // The parent board sends one nybble per sysclk
    // Word order on the wire is least significant nybble first

    // One link symbol
    typedef logic [3:0] cin_nybble_t;

    // One command word as assembled on the receive side
    // Bits 31 to 28 carry the opcode
    // Bits 27 to 0 carry the opcode specific fields
    typedef logic [31:0] cin_word_t;

    // Nybbles that make up one word
    // Also the capture period in sysclk cycles once locked
    localparam int CIN_NYBBLES_PER_WORD = 8;

    // Training pattern sent while the link is being aligned
    // Top nybble is hex A so the decoder treats it as training
    // No nybble rotation of the pattern equals the pattern, so a slip shows up
    localparam cin_word_t CIN_DEFAULT_TRAIN = 32'hA55A6996;

endpackage

/* rtl/cin_link_top.sv */
`timescale 1ns/1ns

module cin_link_top #(
    parameter cin_link_pkg::cin_word_t TRAIN_SEQUENCE = cin_link_pkg::CIN_DEFAULT_TRAIN,
    parameter int                      FIFO_DEPTH     = 16
) (
    input  logic                      sysclk_i,
    input  logic                      rst_i,
    input  cin_link_pkg::cin_nybble_t cin_i,
    input  logic                      capture_i,
    input  logic                      lock_i,
    output logic                      locked_o,
    output logic                      biterr_o,
    output logic                      trig_o,
    output cin_cmd_pkg::cin_trig_t    trig_time_o,
    output logic                      regwr_o,
    output cin_cmd_pkg::cin_regwr_t   regwr_data_o,
    output logic [7:0]                bad_cmd_cnt_o,
    output logic                      fifo_overflow_o
);
    import cin_link_pkg::*;

    // Producer to FIFO
    cin_word_t sync_word;
    logic      sync_word_stb;
    // FIFO to consumer
    cin_word_t fifo_rd_data;
    logic      fifo_rd;
    logic      fifo_empty;

    // Nybble stream to captured words
    cin_parallel_sync #(
        .TRAIN_SEQUENCE (TRAIN_SEQUENCE)
    ) u_cin_parallel_sync (
        .sysclk_i   (sysclk_i),
        .rst_i      (rst_i),
        .cin_i      (cin_i),
        .capture_i  (capture_i),
        .lock_i     (lock_i),
        .locked_o   (locked_o),
        .word_o     (sync_word),
        .word_stb_o (sync_word_stb),
        .biterr_o   (biterr_o)
    );

    // Absorbs forced capture bursts
    // Full and level are left for debug use
    cin_word_fifo #(
        .payload_t  (cin_word_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cin_word_fifo (
        .sysclk_i   (sysclk_i),
        .rst_i      (rst_i),
        .wr_i       (sync_word_stb),
        .wr_data_i  (sync_word),
        .rd_i       (fifo_rd),
        .rd_data_o  (fifo_rd_data),
        .empty_o    (fifo_empty),
        .full_o     (),
        .level_o    (),
        .overflow_o (fifo_overflow_o)
    );

    // Words to triggers and register writes
    cin_cmd_decoder u_cin_cmd_decoder (
        .sysclk_i      (sysclk_i),
        .rst_i         (rst_i),
        .word_i        (fifo_rd_data),
        .empty_i       (fifo_empty),
        .rd_o          (fifo_rd),
        .trig_o        (trig_o),
        .trig_time_o   (trig_time_o),
        .regwr_o       (regwr_o),
        .regwr_data_o  (regwr_data_o),
        .bad_cmd_cnt_o (bad_cmd_cnt_o)
    );

endmodule

/* rtl/cin_nybble_delay.sv */
`timescale 1ns/1ns

module cin_nybble_delay (
    input  logic                      sysclk_i,
    input  cin_link_pkg::cin_nybble_t din_i,
    output cin_link_pkg::cin_nybble_t dout_o
);
    import cin_link_pkg::*;

    // One stage per nybble in a word
    // Output is the nybble from exactly one word period back
    localparam int DEPTH = CIN_NYBBLES_PER_WORD;

    cin_nybble_t stage [DEPTH];

    // Plain shift chain
    always_ff @(posedge sysclk_i) begin
        stage[0] <= din_i;
        for (int i = 1; i < DEPTH; i++) begin
            stage[i] <= stage[i-1];
        end
    end

    // Last stage is the oldest
    assign dout_o = stage[DEPTH-1];

endmodule

/* rtl/cin_parallel_sync.sv */
`timescale 1ns/1ns

module cin_parallel_sync #(
    parameter cin_link_pkg::cin_word_t TRAIN_SEQUENCE = cin_link_pkg::CIN_DEFAULT_TRAIN
) (
    input  logic                      sysclk_i,
    input  logic                      rst_i,
    input  cin_link_pkg::cin_nybble_t cin_i,
    input  logic                      capture_i,
    input  logic                      lock_i,
    output logic                      locked_o,
    output cin_link_pkg::cin_word_t   word_o,
    output logic                      word_stb_o,
    output logic                      biterr_o
);
    import cin_link_pkg::*;

    localparam int NYB_W   = $bits(cin_nybble_t);
    // History holds every nybble of the window except the incoming one
    localparam int HIST_W  = (CIN_NYBBLES_PER_WORD - 1) * NYB_W;
    localparam int PHASE_W = $clog2(CIN_NYBBLES_PER_WORD);
    localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(CIN_NYBBLES_PER_WORD - 1);

    logic [HIST_W-1:0]  history;
    cin_word_t          window;
    logic               enable_lock;
    logic [PHASE_W-1:0] phase;
    logic               sched_capture;
    logic               do_capture;
    cin_nybble_t        oldest;
    cin_nybble_t        oldest_dly;

    // Least significant nybble comes first so shift right
    // Newest nybble enters at the top
    always_ff @(posedge sysclk_i) begin
        history <= {cin_i, history[HIST_W-1:NYB_W]};
    end

    // Incoming nybble completes the window this cycle
    assign window = {cin_i, history};

    // Lock request is sticky until reset
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            enable_lock <= 1'b0;
        end else if (lock_i) begin
            enable_lock <= 1'b1;
        end
    end

    // Lock on the first full training word after enable
    // Word boundary never moves after that
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            locked_o <= 1'b0;
        end else if (enable_lock && (window == TRAIN_SEQUENCE)) begin
            locked_o <= 1'b1;
        end
    end

    // Phase within the word
    // Held at zero while unlocked so the first lap starts at the lock edge
    always_ff @(posedge sysclk_i) begin
        if (rst_i || !locked_o) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // Last phase sees the next aligned word complete in the window
    assign sched_capture = locked_o && (phase == LAST_PHASE);
    // Forced capture works whether locked or not
    assign do_capture = sched_capture || capture_i;

    // Captured word is payload only
    always_ff @(posedge sysclk_i) begin
        if (do_capture) begin
            word_o <= window;
        end
    end

    // Strobe lines up with the freshly loaded word
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            word_stb_o <= 1'b0;
        end else begin
            word_stb_o <= do_capture;
        end
    end

    // Bit error check works on the oldest history nybble
    // Delay line returns the nybble from one word earlier
    assign oldest = history[NYB_W-1:0];

    cin_nybble_delay u_cin_nybble_delay (
        .sysclk_i (sysclk_i),
        .din_i    (oldest),
        .dout_o   (oldest_dly)
    );

    // Repeating training word means every nybble matches one word back
    // Only checked while unlocked so training can stop after lock
    always_ff @(posedge sysclk_i) begin
        if (rst_i || locked_o) begin
            biterr_o <= 1'b0;
        end else begin
            biterr_o <= (oldest != oldest_dly);
        end
    end

endmodule

/* rtl/cin_word_fifo.sv */
`timescale 1ns/1ns

module cin_word_fifo #(
    parameter type payload_t  = logic [31:0],
    parameter int  FIFO_DEPTH = 16
) (
    input  logic                        sysclk_i,
    input  logic                        rst_i,
    input  logic                        wr_i,
    input  payload_t                    wr_data_i,
    input  logic                        rd_i,
    output payload_t                    rd_data_o,
    output logic                        empty_o,
    output logic                        full_o,
    output logic [$clog2(FIFO_DEPTH):0] level_o,
    output logic                        overflow_o
);
    // Depth must be a power of two so the pointers wrap cleanly
    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    payload_t          mem [FIFO_DEPTH];
    // Extra top bit tells full from empty
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;
    logic              do_wr;
    logic              do_rd;

    // Writes into a full buffer are dropped
    assign do_wr = wr_i && !full_o;
    // Reads from an empty buffer are ignored
    assign do_rd = rd_i && !empty_o;

    // Same address with equal wrap bits means nothing stored
    assign empty_o = (wr_ptr == rd_ptr);
    // Same address with opposite wrap bits means every slot used
    assign full_o  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    // Occupancy including the full case
    assign level_o = wr_ptr - rd_ptr;

    // Storage
    always_ff @(posedge sysclk_i) begin
        if (do_wr) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data_i;
        end
    end

    // Registered read port
    // Popped word is valid the cycle after rd_i
    always_ff @(posedge sysclk_i) begin
        if (do_rd) begin
            rd_data_o <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    // Pointers
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Sticky overflow
    // Link cannot stall so a lost word is only reported
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            overflow_o <= 1'b0;
        end else if (wr_i && full_o) begin
            overflow_o <= 1'b1;
        end
    end

endmodule

/* verif/cin_link_tb_tasks.svh */
// One nybble per rising edge, capture request rides along
task automatic drive_nybble(input cin_nybble_t nyb, input logic cap);
    @(posedge sysclk_i);
    cin_i     <= nyb;
    capture_i <= cap;
    sent_hist = {nyb, sent_hist[31:4]};
endtask

// Least significant nybble first
task automatic send_word(input cin_word_t word);
    for (int i = 0; i < CIN_NYBBLES_PER_WORD; i++) begin
        drive_nybble(word[4*i +: 4], 1'b0);
    end
endtask

// Two training words, then lock enabled for the third
// Lock lands on the edge after this returns
task automatic lock_link();
    send_word(CIN_DEFAULT_TRAIN);
    send_word(CIN_DEFAULT_TRAIN);
    lock_i <= 1'b1;
    send_word(CIN_DEFAULT_TRAIN);
    lock_i <= 1'b0;
endtask

// Wait until the decoder has pulsed want times in total
task automatic wait_pulse(input int want);
    int waited;
    waited = 0;
    while (trig_seen.size() + regwr_seen.size() < want) begin
        if (waited >= PULSE_TIMEOUT) begin
            fail_run("Decoder pulse did not arrive in time");
        end else begin
            @(negedge sysclk_i);
            waited++;
        end
    end
endtask

task automatic test_lock_enable();
    apply_reset();
    @(negedge sysclk_i);
    check_eq("locked_o", 0, locked_o);
    check_eq("trig_o", 0, trig_o);
    check_eq("regwr_o", 0, regwr_o);
    // Aligned training words but no lock request
    repeat (4) send_word(CIN_DEFAULT_TRAIN);
    @(negedge sysclk_i);
    check_eq("locked_o", 0, locked_o);
    lock_link();
    send_word('0);
    @(negedge sysclk_i);
    check_eq("locked_o", 1, locked_o);
endtask

task automatic test_biterr();
    apply_reset();
    // Fill history and delay line with training data first
    repeat (3) send_word(CIN_DEFAULT_TRAIN);
    biterr_hits = 0;
    repeat (2) send_word(CIN_DEFAULT_TRAIN);
    @(negedge sysclk_i);
    check_eq("biterr_o high count", 0, biterr_hits);
    // Flip one nybble in the middle of a word
    send_word(CIN_DEFAULT_TRAIN ^ 32'h0000_5000);
    send_word(CIN_DEFAULT_TRAIN);
    @(negedge sysclk_i);
    check_eq("biterr_o seen", 1, biterr_hits != 0);
    lock_link();
    send_word(CIN_DEFAULT_TRAIN);
    @(negedge sysclk_i);
    check_eq("locked_o", 1, locked_o);
    biterr_hits = 0;
    repeat (4) send_word($urandom());
    @(negedge sysclk_i);
    check_eq("biterr_o high count", 0, biterr_hits);
endtask

task automatic test_trigger();
    logic [27:0] exp_time[$];
    logic [31:0] rnd;
    cin_word_t   word;
    apply_reset();
    lock_link();
    // Training and idle between triggers must stay silent
    for (int i = 0; i < 4; i++) begin
        rnd  = $urandom();
        word = {OP_TRIG, rnd[27:0]};
        exp_time.push_back(word[27:0]);
        send_word(word);
        send_word(CIN_DEFAULT_TRAIN);
        send_word('0);
    end
    wait_pulse(4);
    repeat (2) send_word('0);
    @(negedge sysclk_i);
    check_eq("trig_o count", 4, trig_seen.size());
    check_eq("regwr_o count", 0, regwr_seen.size());
    foreach (exp_time[i]) begin
        check_eq("trig_time_o", exp_time[i], trig_seen[i]);
    end
    check_eq("fifo_overflow_o", 0, fifo_overflow_o);
endtask

task automatic test_regwr();
    cin_regwr_t  exp_wr[$];
    cin_regwr_t  one;
    logic [31:0] rnd_addr;
    logic [31:0] rnd_data;
    cin_word_t   word;
    apply_reset();
    lock_link();
    for (int i = 0; i < 4; i++) begin
        rnd_addr = $urandom();
        rnd_data = $urandom();
        word     = {OP_REGWR, rnd_addr[7:0], rnd_data[19:0]};
        // Address in bits 27 to 20, data below
        one.addr = word[27:20];
        one.data = word[19:0];
        exp_wr.push_back(one);
        send_word(word);
        send_word('0);
    end
    wait_pulse(4);
    repeat (2) send_word('0);
    @(negedge sysclk_i);
    check_eq("regwr_o count", 4, regwr_seen.size());
    check_eq("trig_o count", 0, trig_seen.size());
    foreach (exp_wr[i]) begin
        check_eq("regwr_data_o.addr", exp_wr[i].addr, regwr_seen[i].addr);
        check_eq("regwr_data_o.data", exp_wr[i].data, regwr_seen[i].data);
    end
    check_eq("fifo_overflow_o", 0, fifo_overflow_o);
endtask

task automatic test_bad_opcode();
    int          pick;
    logic [3:0]  op;
    logic [31:0] rnd;
    apply_reset();
    lock_link();
    for (int i = 1; i <= 5; i++) begin
        // Any opcode from 3 to F except A
        pick = $urandom_range(3, 14);
        if (pick >= 10) begin
            pick++;
        end
        op  = pick[3:0];
        rnd = $urandom();
        send_word({op, rnd[27:0]});
        send_word('0);
        @(negedge sysclk_i);
        check_eq("bad_cmd_cnt_o", i, bad_cmd_cnt_o);
    end
    check_eq("trig_o count", 0, trig_seen.size());
    check_eq("regwr_o count", 0, regwr_seen.size());
endtask

task automatic test_forced_capture();
    logic [31:0] rnd;
    cin_word_t   window;
    apply_reset();
    // Link stays unlocked, only capture_i can load a word
    for (int k = 0; k < 2; k++) begin
        rnd = $urandom();
        for (int i = 0; i < 7; i++) begin
            drive_nybble(rnd[4*i +: 4], 1'b0);
        end
        // Opcode nybble completes the window on the capture edge
        drive_nybble((k == 0) ? OP_TRIG : OP_REGWR, 1'b1);
        window = sent_hist;
        drive_nybble(4'h0, 1'b0);
        wait_pulse(k + 1);
        repeat (2) send_word('0);
        @(negedge sysclk_i);
        check_eq("trig_o count", 1, trig_seen.size());
        check_eq("regwr_o count", k, regwr_seen.size());
        check_eq("bad_cmd_cnt_o", 0, bad_cmd_cnt_o);
        check_eq("fifo_overflow_o", 0, fifo_overflow_o);
        if (k == 0) begin
            check_eq("trig_time_o", window[27:0], trig_seen[0]);
        end else begin
            check_eq("regwr_data_o.addr", window[27:20], regwr_seen[0].addr);
            check_eq("regwr_data_o.data", window[19:0], regwr_seen[0].data);
        end
    end
endtask

/* verif/cin_link_tb.sv */
`timescale 1ns/1ns

module cin_link_tb;
    import cin_link_pkg::*;
    import cin_cmd_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    // About 72 words go out over all tests, rounded up
    localparam int TOTAL_WORDS  = 80;
    localparam int WATCHDOG_NS  = TOTAL_WORDS * CIN_NYBBLES_PER_WORD * CLK_PERIOD + 2000;
    // Longest wait for a decoder pulse once the stream is idle
    localparam int PULSE_TIMEOUT = 64;

    logic        sysclk_i;
    logic        rst_i;
    cin_nybble_t cin_i;
    logic        capture_i;
    logic        lock_i;
    logic        locked_o;
    logic        biterr_o;
    logic        trig_o;
    cin_trig_t   trig_time_o;
    logic        regwr_o;
    cin_regwr_t  regwr_data_o;
    logic [7:0]  bad_cmd_cnt_o;
    logic        fifo_overflow_o;

    // Decoder results in arrival order
    cin_trig_t   trig_seen[$];
    cin_regwr_t  regwr_seen[$];
    // Cycles with the bit error flag up
    int          biterr_hits;
    // Last 8 nybbles driven, newest on top like the DUT window
    cin_word_t   sent_hist;

    cin_link_top u_cin_link_top (
        .sysclk_i        (sysclk_i),
        .rst_i           (rst_i),
        .cin_i           (cin_i),
        .capture_i       (capture_i),
        .lock_i          (lock_i),
        .locked_o        (locked_o),
        .biterr_o        (biterr_o),
        .trig_o          (trig_o),
        .trig_time_o     (trig_time_o),
        .regwr_o         (regwr_o),
        .regwr_data_o    (regwr_data_o),
        .bad_cmd_cnt_o   (bad_cmd_cnt_o),
        .fifo_overflow_o (fifo_overflow_o)
    );

    initial sysclk_i = 1'b0;

    always begin
        #(CLK_PERIOD / 2);
        sysclk_i = ~sysclk_i;
    end

    // Outputs sampled mid-cycle, well away from the active edge
    always @(negedge sysclk_i) begin
        if (trig_o) begin
            trig_seen.push_back(trig_time_o);
        end
        if (regwr_o) begin
            regwr_seen.push_back(regwr_data_o);
        end
        if (biterr_o) begin
            biterr_hits++;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch on %s: expected 0x%h, got 0x%h", name, exp, act));
        end
    endtask

    // Synchronous reset with the link quiet
    task automatic apply_reset();
        @(posedge sysclk_i);
        rst_i     <= 1'b1;
        cin_i     <= '0;
        capture_i <= 1'b0;
        lock_i    <= 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk_i);
        rst_i <= 1'b0;
        sent_hist = '0;
        trig_seen.delete();
        regwr_seen.delete();
        biterr_hits = 0;
    endtask

    `include "cin_link_tb_tasks.svh"

    initial begin
        fail_watchdog();
    end

    initial begin
        rst_i       = 1'b1;
        cin_i       = '0;
        capture_i   = 1'b0;
        lock_i      = 1'b0;
        sent_hist   = '0;
        biterr_hits = 0;
        void'($urandom(32'hd7ea));
        test_lock_enable();
        test_biterr();
        test_trigger();
        test_regwr();
        test_bad_opcode();
        test_forced_capture();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Bounded run time
    task automatic fail_watchdog();
        #(WATCHDOG_NS);
        fail_run("Watchdog expired before the test sequence finished");
    endtask

endmodule
